// File: vlog.f
+incdir+verilog
verilog/ttl_bus_pkg.sv
verilog/octal_reg_bank.sv
verilog/jk_flag_bank.sv
verilog/bus_sequencer.sv
verilog/ttl_bus_top.sv
tb/ttl_bus_asserts.sv
tb/ttl_bus_tb.sv

// File: Makefile
TOP := ttl_bus_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module ttl_bus_top -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: tb/ttl_bus_tb.sv
`include "ttl_bus_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module ttl_bus_tb
   import ttl_bus_pkg::*;
();

   localparam int N_TXN   = 96;                // Transactions over all tests
   localparam int MAX_CYC = N_TXN * 8 + 100;   // Run limit in clock cycles
   localparam int ACK_LAT = 3;                 // Edges from req drive to ack seen high

   logic      clk = 1'b0;
   logic      rst;
   host_req_t host;
   logic      ack;
   bus_rsp_t  rsp;

   // Reference model state
   logic [7:0]                ref_regs [`TTL_NUM_REGS];
   logic [`TTL_NUM_FLAGS-1:0] ref_flags;

   int errors = 0;
   int checks = 0;
   int cycles = 0;
   int seed   = 32'h3084;

   ttl_bus_top u_dut (.clk(clk), .rst(rst), .host(host), .ack(ack), .rsp(rsp));

   bind ttl_bus_top ttl_bus_asserts u_asserts
      (.clk(clk), .rst(rst), .req(host.req), .ack(ack), .rsp(rsp));

   always #10 clk = ~clk;   // 20 ns period

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYC) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // Compare tasks

   task automatic check_ack(input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0d ns: ack got %b, expected %b", $time, got, exp);
      end
   endtask

   task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0d ns: rsp got data %h flags %b, expected data %h flags %b",
                  $time, got.data, got.flags, exp.data, exp.flags);
      end
   endtask

   //////////////////////////////
   // Command words and model

   function automatic cmd_u make_xfer(input logic [1:0] op, input reg_idx_t src,
                                      input reg_idx_t dst, input logic use_imm,
                                      input logic [7:0] imm);
      return cmd_u'(xfer_cmd_t'{op, src, dst, use_imm, imm, 1'b0});
   endfunction

   function automatic cmd_u make_flag(input flag_idx_t sel, input logic [1:0] code);
      return cmd_u'(flag_cmd_t'{`TTL_OP_FLAG, sel, code, 10'h000});
   endfunction

   // Updates the model and returns the expected response
   task automatic model_apply(input cmd_u c, output bus_rsp_t exp);
      logic [7:0] v;
      v = 8'h00;   // Flag and reserved commands put 0 on the bus
      case (c.xfer.op)
         `TTL_OP_XFER: begin
            v = c.xfer.use_imm ? c.xfer.imm : ref_regs[c.xfer.src_sel];
            ref_regs[c.xfer.dst_sel] = v;
         end
         `TTL_OP_FLAG: begin
            case (c.flag.jk)
               `TTL_JK_CLR: ref_flags[c.flag.flag_sel] = 1'b0;
               `TTL_JK_SET: ref_flags[c.flag.flag_sel] = 1'b1;
               `TTL_JK_TOG: ref_flags[c.flag.flag_sel] = ~ref_flags[c.flag.flag_sel];
               default:     ;   // Hold
            endcase
         end
         `TTL_OP_READ: v = ref_regs[c.xfer.src_sel];
         default:      ;       // Reserved op leaves everything as is
      endcase
      exp.data  = v;
      exp.flags = ref_flags;
   endtask

   // One four-phase transaction starting and ending 2 ns after a rising edge
   task automatic do_cmd(input cmd_u c, input int hold);
      bus_rsp_t exp;
      bus_rsp_t held;
      int       n;
      model_apply(c, exp);
      host.cmd = c;
      host.req = 1'b1;
      n = 0;
      while (!ack && n < ACK_LAT + 4) begin
         @(posedge clk);
         #2;
         n++;
      end
      checks++;
      if (!ack) begin
         errors++;
         $display("Request not acknowledged within %0d cycles, at %0d ns", n, $time);
      end else if (n != ACK_LAT) begin
         errors++;
         $display("** Error at %0d ns: ack latency got %0d, expected %0d", $time, n, ACK_LAT);
      end
      check_rsp(rsp, exp);
      held = rsp;
      repeat (hold) begin   // Back-pressure with req kept high
         @(posedge clk);
         #2;
         check_ack(ack, 1'b1);
         check_rsp(rsp, held);
      end
      host.req = 1'b0;
      @(posedge clk);
      #2;
      check_ack(ack, 1'b0);   // Gone one edge after req drops
   endtask

   //////////////////////////////
   // Tests

   task automatic reset_state;
      int e0;
      e0 = errors;
      check_ack(ack, 1'b0);
      check_rsp(rsp, '0);
      for (int r = 0; r < `TTL_NUM_REGS; r++)
         do_cmd(make_xfer(`TTL_OP_READ, reg_idx_t'(r), '0, 1'b0, 8'h00), 0);
      $display("[%0d ns] reset_state: %0d errors", $time, errors - e0);
   endtask

   task automatic imm_load;
      int e0;
      e0 = errors;
      for (int r = 0; r < `TTL_NUM_REGS; r++)   // Distinct value per register
         do_cmd(make_xfer(`TTL_OP_XFER, '0, reg_idx_t'(r), 1'b1, 8'hA5 ^ 8'(r * 59)), 0);
      for (int r = 0; r < `TTL_NUM_REGS; r++)
         do_cmd(make_xfer(`TTL_OP_READ, reg_idx_t'(r), '0, 1'b0, 8'h00), 0);
      $display("[%0d ns] imm_load: %0d errors", $time, errors - e0);
   endtask

   task automatic reg_copy;
      int e0;
      e0 = errors;
      do_cmd(make_xfer(`TTL_OP_XFER, 2'd0, 2'd2, 1'b0, 8'hFF), 0);   // imm ignored
      do_cmd(make_xfer(`TTL_OP_READ, 2'd2, '0, 1'b0, 8'h00), 0);
      do_cmd(make_xfer(`TTL_OP_READ, 2'd0, '0, 1'b0, 8'h00), 0);     // Source intact
      do_cmd(make_xfer(`TTL_OP_XFER, 2'd3, 2'd1, 1'b0, 8'h00), 0);
      do_cmd(make_xfer(`TTL_OP_READ, 2'd1, '0, 1'b0, 8'h00), 0);
      do_cmd(make_xfer(`TTL_OP_READ, 2'd3, '0, 1'b0, 8'h00), 0);
      $display("[%0d ns] reg_copy: %0d errors", $time, errors - e0);
   endtask

   task automatic jk_flags;
      logic [1:0] codes [4] = '{`TTL_JK_TOG, `TTL_JK_HOLD, `TTL_JK_CLR, `TTL_JK_SET};
      int         e0;
      e0 = errors;
      for (int f = 0; f < `TTL_NUM_FLAGS; f++)
         for (int k = 0; k < 4; k++)
            do_cmd(make_flag(flag_idx_t'(f), codes[k]), 0);
      $display("[%0d ns] jk_flags: %0d errors", $time, errors - e0);
   endtask

   task automatic handshake;
      int e0;
      e0 = errors;
      do_cmd(make_xfer(`TTL_OP_READ, 2'd1, '0, 1'b0, 8'h00), 5);   // Host slow to drop req
      do_cmd(make_flag(2'd2, `TTL_JK_TOG), 0);                    // Right after ack low
      $display("[%0d ns] handshake: %0d errors", $time, errors - e0);
   endtask

   task automatic random_cmds;
      int   rnd;
      cmd_u c;
      int   e0;
      e0 = errors;
      for (int i = 0; i < 60; i++) begin
         rnd       = $random(seed);
         c         = rnd[15:0];
         c.xfer.op = 2'(i % 4);   // Every opcode including reserved
         do_cmd(c, i % 3);
      end
      $display("[%0d ns] random_cmds: %0d errors", $time, errors - e0);
   endtask

   //////////////////////////////
   // Main sequence

   initial begin
      rst  = 1'b0;
      host = '0;
      foreach (ref_regs[i])
         ref_regs[i] = 8'h00;
      ref_flags = '0;
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b1;
      reset_state();
      imm_load();
      reg_copy();
      jk_flags();
      handshake();
      random_cmds();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/ttl_bus_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake and response rules, bound into ttl_bus_top
module ttl_bus_asserts
   import ttl_bus_pkg::*;
(
   input wire           clk,
   input wire           rst,
   input wire           req,
   input wire           ack,
   input wire bus_rsp_t rsp
);

   // Ack only answers a pending req
   a_ack_rise: assert property (@(posedge clk) disable iff (!rst)
      $rose(ack) |-> $past(req))
      else $error("ack rose with req low");

   // Held req is back-pressure
   a_ack_hold: assert property (@(posedge clk) disable iff (!rst)
      $fell(ack) |-> !$past(req))
      else $error("ack fell while req high");

   a_rsp_stable: assert property (@(posedge clk) disable iff (!rst)
      (ack && $past(ack)) |-> $stable(rsp))
      else $error("rsp changed while ack high");

   a_reset_ack: assert property (@(posedge clk) !rst |=> !ack)   // Cycle after reset
      else $error("ack high right after reset");

endmodule

`default_nettype wire

// File: verilog/ttl_bus_top.sv
`include "ttl_bus_defs.svh"

`timescale 1ns/1ps
`default_nettype none

// Register-and-flag section: sequencer, register bank, flag bank
module ttl_bus_top
   import ttl_bus_pkg::*;
(
   input  wire        clk,
   input  wire        rst,
   input  host_req_t  host,
   output logic       ack,
   output bus_rsp_t   rsp
);

   //////////////////////////////
   // Internal bus and strobes
   reg_idx_t                  rd_sel;
   reg_idx_t                  wr_sel;
   logic [7:0]                rd_data;    // Shared register bus
   logic [7:0]                wr_data;
   logic                      wr_en;
   flag_idx_t                 flag_sel;
   logic [1:0]                jk;
   logic                      flag_en;
   logic [`TTL_NUM_FLAGS-1:0] flags;

   bus_sequencer u_seq (
      .clk      (clk),
      .rst      (rst),
      .host     (host),
      .ack      (ack),
      .rsp      (rsp),
      .rd_sel   (rd_sel),
      .rd_data  (rd_data),
      .wr_en    (wr_en),
      .wr_sel   (wr_sel),
      .wr_data  (wr_data),
      .flag_sel (flag_sel),
      .jk       (jk),
      .flag_en  (flag_en),
      .flags    (flags)
   );

   octal_reg_bank u_regs (
      .clk     (clk),
      .rst     (rst),
      .rd_sel  (rd_sel),
      .rd_data (rd_data),
      .wr_en   (wr_en),
      .wr_sel  (wr_sel),
      .wr_data (wr_data)
   );

   jk_flag_bank u_flags (
      .clk      (clk),
      .rst      (rst),
      .flag_sel (flag_sel),
      .jk       (jk),
      .flag_en  (flag_en),
      .flags    (flags)
   );

endmodule

`default_nettype wire

// File: verilog/bus_sequencer.sv
`include "ttl_bus_defs.svh"

`timescale 1ns/1ps
`default_nettype none

// Four-phase req/ack front end, runs one command at a time
module bus_sequencer
   import ttl_bus_pkg::*;
(
   input  wire                        clk,
   input  wire                        rst,
   input  wire  host_req_t            host,
   output logic                       ack,
   output bus_rsp_t                   rsp,
   output logic [REG_IDX_W-1:0]       rd_sel,
   input  wire  [7:0]                 rd_data,
   output logic                       wr_en,
   output logic [REG_IDX_W-1:0]       wr_sel,
   output logic [7:0]                 wr_data,
   output logic [FLG_IDX_W-1:0]       flag_sel,
   output logic [1:0]                 jk,
   output logic                       flag_en,
   input  wire  [`TTL_NUM_FLAGS-1:0]  flags
);

   // FSM encoding
   localparam logic [1:0] S_IDLE     = 2'd0;
   localparam logic [1:0] S_EXEC     = 2'd1;   // Write or flag update this cycle
   localparam logic [1:0] S_RESP     = 2'd2;   // Capture response
   localparam logic [1:0] S_WAIT_LOW = 2'd3;   // Ack high until req drops

   logic [1:0] state;
   cmd_u       cmd_q;      // Command latched on entry to EXEC
   logic [1:0] op_q;
   logic [7:0] bus_val;    // Value on the internal bus

   assign op_q = cmd_q.xfer.op;   // Same top bits in both views

   //////////////////////////////
   // Register bank steering

   assign rd_sel  = cmd_q.xfer.src_sel;
   assign wr_sel  = cmd_q.xfer.dst_sel;
   assign wr_data = bus_val;
   assign wr_en   = (state == S_EXEC) && (op_q == `TTL_OP_XFER);   // One-cycle strobe

   // Flag bank steering, flag view of the same word
   assign flag_sel = cmd_q.flag.flag_sel;
   assign jk       = cmd_q.flag.jk;
   assign flag_en  = (state == S_EXEC) && (op_q == `TTL_OP_FLAG);

   // Bus source by opcode
   always_comb begin
      case (op_q)
         `TTL_OP_XFER: bus_val = cmd_q.xfer.use_imm ? cmd_q.xfer.imm : rd_data;
         `TTL_OP_READ: bus_val = rd_data;
         `TTL_OP_FLAG: bus_val = 8'h00;   // Flags never drive the bus
         default:      bus_val = 8'h00;   // Reserved op, nothing on the bus
      endcase
   end

   //////////////////////////////
   // Handshake FSM

   always_ff @(posedge clk) begin
      if (!rst) begin
         state <= S_IDLE;
         ack   <= 1'b0;
         rsp   <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (host.req)
                  state <= S_EXEC;
            end
            S_EXEC: begin
               state <= S_RESP;   // Bank writes land at this edge
            end
            S_RESP: begin
               // Src unchanged by a copy unless src == dst, same value then
               rsp.data  <= bus_val;
               rsp.flags <= flags;     // Already updated
               ack       <= 1'b1;
               state     <= S_WAIT_LOW;
            end
            S_WAIT_LOW: begin
               // Held req is back-pressure, rsp frozen meanwhile
               if (!host.req) begin
                  ack   <= 1'b0;
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Command capture
   always_ff @(posedge clk) begin
      if ((state == S_IDLE) && host.req)
         cmd_q <= host.cmd;
   end

endmodule

`default_nettype wire

// File: verilog/jk_flag_bank.sv
`include "ttl_bus_defs.svh"

`timescale 1ns/1ps
`default_nettype none

// JK flag bits, 74x112 table on the rising edge
module jk_flag_bank
   import ttl_bus_pkg::*;
(
   input  wire                        clk,
   input  wire                        rst,
   input  wire  [FLG_IDX_W-1:0]       flag_sel,
   input  wire  [1:0]                 jk,
   input  wire                        flag_en,
   output logic [`TTL_NUM_FLAGS-1:0]  flags
);

   logic [`TTL_NUM_FLAGS-1:0] flags_d;   // Next flag state

   // One JK cell
   function automatic logic jk_next(input logic q, input logic [1:0] code);
      logic n;
      case (code)
         `TTL_JK_HOLD: n = q;
         `TTL_JK_CLR:  n = 1'b0;
         `TTL_JK_SET:  n = 1'b1;
         `TTL_JK_TOG:  n = ~q;
         default:      n = q;
      endcase
      return n;
   endfunction

   //////////////////////////////
   // Next state, selected flag only

   always_comb begin
      for (int i = 0; i < `TTL_NUM_FLAGS; i++) begin
         if (flag_en && (flag_sel == flag_idx_t'(i)))
            flags_d[i] = jk_next(flags[i], jk);
         else
            flags_d[i] = flags[i];   // Unselected flags hold
      end
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         flags <= '0;
      end else begin
         flags <= flags_d;
      end
   end

endmodule

`default_nettype wire

// File: verilog/octal_reg_bank.sv
`include "ttl_bus_defs.svh"

`timescale 1ns/1ps
`default_nettype none

// Octal D registers sharing one internal bus, 574 style
module octal_reg_bank
   import ttl_bus_pkg::*;
(
   input  wire        clk,
   input  wire        rst,
   input  wire        [REG_IDX_W-1:0] rd_sel,
   output logic [7:0] rd_data,
   input  wire        wr_en,
   input  wire        [REG_IDX_W-1:0] wr_sel,
   input  wire        [7:0] wr_data
);

   logic [7:0]               regs [`TTL_NUM_REGS];  // Register contents
   logic [`TTL_NUM_REGS-1:0] oe_n;                  // Output enables, active low
   logic [`TTL_NUM_REGS-1:0] we;                    // Per-register clock enables

   //////////////////////////////
   // Select decode

   always_comb begin
      for (int i = 0; i < `TTL_NUM_REGS; i++) begin
         // Only the addressed register drops its /OE
         oe_n[i] = (rd_sel != reg_idx_t'(i));
         we[i]   = wr_en && (wr_sel == reg_idx_t'(i));
      end
   end

   //////////////////////////////
   // Storage

   always_ff @(posedge clk) begin
      if (!rst) begin
         for (int i = 0; i < `TTL_NUM_REGS; i++) begin
            regs[i] <= 8'h00;    // All registers clear
         end
      end else begin
         for (int i = 0; i < `TTL_NUM_REGS; i++) begin
            if (we[i]) begin
               regs[i] <= wr_data;   // Single write port
            end
         end
      end
   end

   //////////////////////////////
   // Bus driver

   // AND-OR in place of tri-state outputs
   // One-hot enables, so never two drivers at once
   always_comb begin
      rd_data = 8'h00;
      for (int i = 0; i < `TTL_NUM_REGS; i++) begin
         rd_data = rd_data | (regs[i] & {8{~oe_n[i]}});
      end
   end

endmodule

`default_nettype wire

// File: verilog/ttl_bus_pkg.sv
`default_nettype none

`include "ttl_bus_defs.svh"

package ttl_bus_pkg;

   localparam int CMD_W     = 16;                       // Command word width
   localparam int REG_IDX_W = $clog2(`TTL_NUM_REGS);    // Register select width
   localparam int FLG_IDX_W = $clog2(`TTL_NUM_FLAGS);   // Flag select width

   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [FLG_IDX_W-1:0] flag_idx_t;

   //////////////////////////////
   // Transfer view, also used by READ (src_sel only)
   typedef struct packed {
      logic [1:0] op;
      reg_idx_t   src_sel;       // Register driving the bus
      reg_idx_t   dst_sel;       // Register loaded from the bus
      logic       use_imm;       // Bus sourced from imm instead
      logic [7:0] imm;
      logic [CMD_W-2-2*REG_IDX_W-9-1:0] spare;
   } xfer_cmd_t;

   // Flag view
   typedef struct packed {
      logic [1:0] op;            // Same bits as xfer op
      flag_idx_t  flag_sel;
      logic [1:0] jk;            // {j,k}
      logic [CMD_W-2-FLG_IDX_W-2-1:0] spare;
   } flag_cmd_t;

   // One command word, two decodes
   typedef union packed {
      xfer_cmd_t xfer;
      flag_cmd_t flag;
   } cmd_u;

   //////////////////////////////
   typedef struct packed {
      logic req;                 // Four-phase request
      cmd_u cmd;                 // Held stable while req high
   } host_req_t;

   typedef struct packed {
      logic [7:0]                data;   // Bus value of the command
      logic [`TTL_NUM_FLAGS-1:0] flags;  // Flag state after the command
   } bus_rsp_t;

endpackage

`default_nettype wire

// File: verilog/ttl_bus_defs.svh
`ifndef TTL_BUS_DEFS_SVH
`define TTL_BUS_DEFS_SVH

// Bank sizes
`define TTL_NUM_REGS  4      // 8-bit registers on the internal bus
`define TTL_NUM_FLAGS 4      // JK flag bits

//////////////////////////////
// Command opcodes, top two bits of every command word
`define TTL_OP_XFER   2'd0   // Immediate load or register copy
`define TTL_OP_FLAG   2'd1   // JK code on one flag
`define TTL_OP_READ   2'd2   // Register read
// 2'd3 reserved, answered without side effects

//////////////////////////////
// JK codes as {j,k}, same as the 74x112 table
`define TTL_JK_HOLD   2'b00
`define TTL_JK_CLR    2'b01
`define TTL_JK_SET    2'b10
`define TTL_JK_TOG    2'b11

`endif
